// ==== Makefile ====
# Verilator build and run for the ADC capture testbench

VERILATOR ?= verilator
TOP       ?= adc_capture_tb
FILELIST  ?= adc_capture.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== adc_capture.f ====
common/adc_capture_pkg.sv
hw/capture_ctrl.sv
hw/sample_formatter.sv
stream_rx_buffer/stream_rx_buffer.sv
hw/adc_capture_top.sv
dv/adc_capture_tb.sv

// ==== common/adc_capture_pkg.sv ====
package adc_capture_pkg;

  localparam int SAMPLE_W  = 16;
  localparam int HALF_W    = SAMPLE_W / 2;
  localparam int PKT_LEN_W = 8;

  // One sample word read whole or as an I/Q byte pair
  typedef union packed {
    logic [SAMPLE_W-1:0] full;
    struct packed {
      logic [HALF_W-1:0] i_half;
      logic [HALF_W-1:0] q_half;
    } iq;
  } sample_word_u;

  // Raw ADC input whose valid is a one-cycle strobe
  typedef struct packed {
    logic         valid;
    sample_word_u data;
  } adc_in_t;

  typedef struct packed {
    logic         valid;
    logic         last;
    sample_word_u data;
  } stream_beat_t;

  typedef struct packed {
    logic                 busy;
    logic                 overflow;
    logic [PKT_LEN_W-1:0] pkt_count;
  } capture_status_t;

  typedef enum logic {
    MODE_SINGLE = 1'b0,
    MODE_DUAL   = 1'b1
  } capture_mode_e;

endpackage

// ==== dv/adc_capture_tb.sv ====
module adc_capture_tb
  import adc_capture_pkg::*;
();

  localparam int BUF_DEPTH_LOG2 = 3;
  localparam int DEPTH          = 2 ** BUF_DEPTH_LOG2;
  localparam int N_SAMPLES      = 20;
  localparam int OVF_SENT       = 14;
  localparam int DRAIN_LIMIT    = 100;
  localparam int TEST_CYCLES    = 6 * N_SAMPLES * 5 + 6 * DRAIN_LIMIT + 100;
  localparam logic [SAMPLE_W-1:0] SIGN_SINGLE = 16'h8000;
  localparam logic [SAMPLE_W-1:0] SIGN_DUAL   = 16'h8080;

  typedef struct packed {
    logic         last;
    sample_word_u data;
  } exp_beat_t;

  logic clk, rst, start, stop, m_ready, drain_check, stall_q, armed, bp_mode, ovf_expect;
  capture_mode_e        mode_in, cur_mode;
  logic [PKT_LEN_W-1:0] pkt_len_in, cur_len, pkt_pos;
  adc_in_t              adc;
  stream_beat_t         m_axis, prev_beat;
  capture_status_t      status;
  logic [15:0]          lfsr = 16'd6;
  exp_beat_t            exp_q[$];
  exp_beat_t            exp_head;
  int exp_cnt_q, lasts_seen, lasts_q, beats_seen, err_cnt, cap_limit, cap_used;
  wire xfer = m_axis.valid && m_ready;

  adc_capture_top #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) DUT (
    .clk(clk), .rst(rst), .start(start), .stop(stop), .mode_in(mode_in),
    .pkt_len_in(pkt_len_in), .adc(adc), .m_axis(m_axis), .m_ready(m_ready), .status(status)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (!rst && xfer) begin
      beats_seen++;
      if (m_axis.last) lasts_seen++;
      if (exp_q.size() > 0) void'(exp_q.pop_front());
    end
    stall_q   <= !rst && m_axis.valid && !m_ready;
    prev_beat <= m_axis;
  end

  // Expected head settles half a cycle before the edge that compares it
  always @(negedge clk) begin
    exp_cnt_q <= exp_q.size();
    exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    lasts_q   <= lasts_seen;
  end

  a_reset_state : assert property (@(posedge clk) rst |=> !m_axis.valid && !status.busy
      && !status.overflow && status.pkt_count == '0)
    else begin
      err_cnt++;
      $display("FAIL reset valid/busy/overflow/pkt_count got %h/%h/%h/%h exp 0/0/0/00",
               $sampled(m_axis.valid), $sampled(status.busy), $sampled(status.overflow),
               $sampled(status.pkt_count));
    end
  a_no_extra : assert property (@(posedge clk) disable iff (rst) xfer |-> exp_cnt_q != 0)
    else begin
      err_cnt++;
      $display("Output transfer at %0t with no beat expected", $time);
    end
  a_data : assert property (@(posedge clk) disable iff (rst)
      xfer && exp_cnt_q != 0 |-> m_axis.data == exp_head.data)
    else begin
      err_cnt++;
      $display("FAIL m_axis.data got %h exp %h", $sampled(m_axis.data), exp_head.data);
    end
  a_last : assert property (@(posedge clk) disable iff (rst)
      xfer && exp_cnt_q != 0 |-> m_axis.last == exp_head.last)
    else begin
      err_cnt++;
      $display("FAIL m_axis.last got %h exp %h", $sampled(m_axis.last), exp_head.last);
    end
  a_hold : assert property (@(posedge clk) disable iff (rst) stall_q |->
      m_axis.valid && m_axis.data == prev_beat.data && m_axis.last == prev_beat.last)
    else begin
      err_cnt++;
      $display("FAIL m_axis stalled beat got %h exp %h", $sampled(m_axis),
               $sampled(prev_beat));
    end
  a_busy_on : assert property (@(posedge clk) disable iff (rst) start |=> status.busy)
    else begin
      err_cnt++;
      $display("Capture not busy after start");
    end
  a_busy_off : assert property (@(posedge clk) disable iff (rst) stop && !start |=> !status.busy)
    else begin
      err_cnt++;
      $display("Capture still busy after stop");
    end
  a_ovf_sticky : assert property (@(posedge clk) disable iff (rst)
      status.overflow && !start |=> status.overflow)
    else begin
      err_cnt++;
      $display("Overflow flag dropped without a start");
    end
  a_ovf_clear : assert property (@(posedge clk) disable iff (rst) start |=> !status.overflow)
    else begin
      err_cnt++;
      $display("Overflow flag not cleared by start");
    end
  a_drained : assert property (@(posedge clk) disable iff (rst) drain_check |-> exp_cnt_q == 0)
    else begin
      err_cnt++;
      $display("Expected beats never came out: %0d left", exp_cnt_q);
    end
  a_pkt_count : assert property (@(posedge clk) disable iff (rst)
      drain_check |-> status.pkt_count == lasts_q[PKT_LEN_W-1:0])
    else begin
      err_cnt++;
      $display("FAIL status.pkt_count got %h exp %h", $sampled(status.pkt_count), lasts_q);
    end
  a_ovf_flag : assert property (@(posedge clk) disable iff (rst)
      drain_check |-> status.overflow == ovf_expect)
    else begin
      err_cnt++;
      $display("FAIL status.overflow got %h exp %h", $sampled(status.overflow), ovf_expect);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic tick();
    @(posedge clk);
    #2;
    if (bp_mode) m_ready = |rand_bits(2);
  endtask

  task automatic start_capture(input capture_mode_e m, input logic [PKT_LEN_W-1:0] len);
    start      = 1'b1;
    mode_in    = m;
    pkt_len_in = len;
    armed      = 1'b1;
    cur_mode   = m;
    cur_len    = len;
    pkt_pos    = '0;
    lasts_seen = 0;
    cap_used   = 0;
    tick();
    start = 1'b0;
  endtask

  task automatic stop_capture();
    stop  = 1'b1;
    armed = 1'b0;
    tick();
    stop = 1'b0;
  endtask

  task automatic send_samples(input int n, input bit random_gap);
    logic [31:0]          r;
    sample_word_u         w;
    exp_beat_t            e;
    logic [PKT_LEN_W-1:0] nxt;
    for (int k = 0; k < n; k++) begin
      r      = rand_bits(SAMPLE_W);
      w.full = r[SAMPLE_W-1:0];
      adc    = '{valid: 1'b1, data: w};
      if (armed) begin
        nxt         = pkt_pos + 8'd1;
        e.last      = (nxt == cur_len);
        pkt_pos     = e.last ? '0 : nxt;
        e.data.full = w.full ^ ((cur_mode == MODE_DUAL) ? SIGN_DUAL : SIGN_SINGLE);
        // With ready held low only the store plus the output register survive
        if (cap_limit == 0 || cap_used < cap_limit) exp_q.push_back(e);
        cap_used++;
      end
      tick();
      adc.valid = 1'b0;
      if (random_gap) repeat (rand_bits(2)) tick();
    end
  endtask

  task automatic drain_and_check();
    int waited;
    bp_mode = 1'b0;
    m_ready = 1'b1;
    waited  = 0;
    repeat (4) tick();
    while ((exp_q.size() != 0 || m_axis.valid) && waited < DRAIN_LIMIT) begin
      tick();
      waited++;
    end
    if (waited == DRAIN_LIMIT) begin
      err_cnt++;
      $display("Drain timed out with %0d beats still expected", exp_q.size());
    end
    drain_check = 1'b1;
    tick();
    drain_check = 1'b0;
  endtask

  initial begin
    {clk, start, stop, drain_check, armed, bp_mode, ovf_expect} = '0;
    rst        = 1'b1;
    mode_in    = MODE_SINGLE;
    pkt_len_in = '0;
    adc        = '0;
    m_ready    = 1'b1;
    {err_cnt, beats_seen, lasts_seen, cap_limit, cap_used} = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    // Gating test with a packet cut short by stop
    send_samples(3, 1'b1);
    start_capture(MODE_SINGLE, 8'd4);
    send_samples(6, 1'b1);
    stop_capture();
    send_samples(3, 1'b1);
    drain_and_check();
    start_capture(MODE_SINGLE, 8'd5);
    send_samples(N_SAMPLES, 1'b1);
    drain_and_check();
    start_capture(MODE_DUAL, 8'd7);
    send_samples(N_SAMPLES, 1'b1);
    drain_and_check();
    start_capture(MODE_DUAL, 8'd5);
    bp_mode = 1'b1;
    send_samples(2 * N_SAMPLES, 1'b1);
    drain_and_check();
    // Overflow with the output stalled
    start_capture(MODE_SINGLE, 8'd20);
    m_ready   = 1'b0;
    cap_limit = DEPTH + 1;
    send_samples(OVF_SENT, 1'b0);
    repeat (4) tick();
    ovf_expect = 1'b1;
    drain_and_check();
    cap_limit  = 0;
    ovf_expect = 1'b0;
    start_capture(MODE_SINGLE, 8'd5);
    send_samples(5, 1'b1);
    drain_and_check();
    stop_capture();
    $display("Summary: %0d beats transferred, %0d errors", beats_seen, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 20 + 1000);
    $display("Watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== hw/adc_capture_top.sv ====
module adc_capture_top
  import adc_capture_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 stop,
  input  capture_mode_e        mode_in,
  input  logic [PKT_LEN_W-1:0] pkt_len_in,
  input  adc_in_t              adc,
  output stream_beat_t         m_axis,
  input  logic                 m_ready,
  output capture_status_t      status
);

  adc_in_t       gated;
  logic          gated_last;
  capture_mode_e mode;
  stream_beat_t  fmt_beat;
  logic          overflow_pulse;

  capture_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .stop          (stop),
    .mode_in       (mode_in),
    .pkt_len_in    (pkt_len_in),
    .adc           (adc),
    .overflow_pulse(overflow_pulse),
    .gated         (gated),
    .gated_last    (gated_last),
    .mode          (mode),
    .status        (status)
  );

  sample_formatter u_fmt (
    .clk       (clk),
    .rst       (rst),
    .gated     (gated),
    .gated_last(gated_last),
    .mode      (mode),
    .fmt_beat  (fmt_beat)
  );

  // Buffer absorbs back-pressure because upstream strobes cannot be held off
  stream_rx_buffer #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_buf (
    .clk           (clk),
    .rst           (rst),
    .wr_beat       (fmt_beat),
    .m_axis        (m_axis),
    .m_ready       (m_ready),
    .overflow_pulse(overflow_pulse)
  );

endmodule

// ==== hw/capture_ctrl.sv ====
module capture_ctrl
  import adc_capture_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 stop,
  input  capture_mode_e        mode_in,
  input  logic [PKT_LEN_W-1:0] pkt_len_in,
  input  adc_in_t              adc,
  input  logic                 overflow_pulse,
  output adc_in_t              gated,
  output logic                 gated_last,
  output capture_mode_e        mode,
  output capture_status_t      status
);

  logic                 armed;
  logic                 ovf_sticky;
  capture_mode_e        mode_q;
  logic [PKT_LEN_W-1:0] pkt_len_q;
  logic [PKT_LEN_W-1:0] sample_cnt;
  logic [PKT_LEN_W-1:0] sample_cnt_nxt;
  logic [PKT_LEN_W-1:0] pkt_count;
  logic                 capture_en;
  logic                 pkt_end;
  logic                 gated_valid;
  sample_word_u         gated_data;

  // A strobe on the start or stop cycle belongs to neither run
  assign capture_en     = armed & adc.valid & ~start & ~stop;
  assign sample_cnt_nxt = sample_cnt + 1'b1;
  assign pkt_end        = (sample_cnt_nxt == pkt_len_q);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arming, framing and status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      armed      <= 1'b0;
      ovf_sticky <= 1'b0;
      mode_q     <= MODE_SINGLE;
      pkt_len_q  <= '0;
      sample_cnt <= '0;
      pkt_count  <= '0;
    end else if (start) begin
      armed      <= 1'b1;
      ovf_sticky <= 1'b0;
      mode_q     <= mode_in;
      pkt_len_q  <= pkt_len_in;
      sample_cnt <= '0;
      pkt_count  <= '0;
    end else begin
      if (stop) begin
        armed <= 1'b0;
      end
      if (overflow_pulse) begin
        ovf_sticky <= 1'b1;
      end
      if (capture_en) begin
        if (pkt_end) begin
          sample_cnt <= '0;
          pkt_count  <= pkt_count + 1'b1;
        end else begin
          sample_cnt <= sample_cnt_nxt;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gated_valid <= 1'b0;
      gated_last  <= 1'b0;
    end else begin
      gated_valid <= capture_en;
      gated_last  <= capture_en & pkt_end;
    end
  end

  always_ff @(posedge clk) begin
    gated_data <= adc.data;
  end

  assign gated  = '{valid: gated_valid, data: gated_data};
  assign mode   = mode_q;
  assign status = '{busy: armed, overflow: ovf_sticky, pkt_count: pkt_count};

  a_last_needs_valid : assert property (
    @(posedge clk) disable iff (rst) gated_last |-> gated.valid
  );

endmodule

// ==== hw/sample_formatter.sv ====
module sample_formatter
  import adc_capture_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  adc_in_t       gated,
  input  logic          gated_last,
  input  capture_mode_e mode,
  output stream_beat_t  fmt_beat
);

  sample_word_u conv;
  sample_word_u out_data;
  logic         out_valid;
  logic         out_last;

  // Offset binary to two's complement is a flip of each sign bit
  always_comb begin
    conv = gated.data;
    if (mode == MODE_DUAL) begin
      conv.iq.i_half[HALF_W-1] = ~gated.data.iq.i_half[HALF_W-1];
      conv.iq.q_half[HALF_W-1] = ~gated.data.iq.q_half[HALF_W-1];
    end else begin
      conv.full[SAMPLE_W-1] = ~gated.data.full[SAMPLE_W-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= gated.valid;
      out_last  <= gated_last;
    end
  end

  always_ff @(posedge clk) begin
    out_data <= conv;
  end

  assign fmt_beat = '{valid: out_valid, last: out_last, data: out_data};

endmodule

// ==== stream_rx_buffer/stream_rx_buffer.sv ====
module stream_rx_buffer
  import adc_capture_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 3
) (
  input  logic         clk,
  input  logic         rst,
  input  stream_beat_t wr_beat,
  output stream_beat_t m_axis,
  input  logic         m_ready,
  output logic         overflow_pulse
);

  localparam int DEPTH = 2 ** BUF_DEPTH_LOG2;
  localparam logic [BUF_DEPTH_LOG2:0] FULL_CNT = {1'b1, {BUF_DEPTH_LOG2{1'b0}}};

  typedef struct packed {
    logic         last;
    sample_word_u data;
  } entry_t;

  entry_t                    mem [DEPTH];
  logic [BUF_DEPTH_LOG2-1:0] wr_ptr;
  logic [BUF_DEPTH_LOG2-1:0] rd_ptr;
  logic [BUF_DEPTH_LOG2:0]   fill_cnt;
  logic                      full;
  logic                      empty;
  logic                      wr_en;
  logic                      load;
  entry_t                    rd_entry;
  logic                      out_valid;
  logic                      out_last;
  sample_word_u              out_data;

  assign full     = (fill_cnt == FULL_CNT);
  assign empty    = (fill_cnt == '0);
  assign wr_en    = wr_beat.valid & ~full;
  // Output register refills when empty or when its beat is taken
  assign load     = (~out_valid | m_ready) & ~empty;
  assign rd_entry = mem[rd_ptr];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side where the input never stalls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{last: wr_beat.last, data: wr_beat.data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      fill_cnt       <= '0;
      overflow_pulse <= 1'b0;
    end else begin
      overflow_pulse <= wr_beat.valid & full;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, load})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered valid/ready output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (m_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_last <= rd_entry.last;
      out_data <= rd_entry.data;
    end
  end

  assign m_axis = '{valid: out_valid, last: out_last, data: out_data};

  a_hold_stable : assert property (
    @(posedge clk) disable iff (rst)
    m_axis.valid && !m_ready |=>
      m_axis.valid && $stable(m_axis.data) && $stable(m_axis.last)
  );

  a_fill_bound : assert property (
    @(posedge clk) disable iff (rst) fill_cnt <= FULL_CNT
  );

endmodule
